//--- src/sc_pkg.sv
`default_nettype none

package sc_pkg;

   // operand and stream geometry
   localparam int VAL_W       = 5;
   localparam int STREAM_LEN  = 2 ** VAL_W;   // one full counter sweep
   localparam int LANES       = 16;
   localparam int LANE_CNT_W  = 6;
   localparam int RESULT_W    = 10;
   localparam int PHASE_CNT_W = 5;

   typedef logic [VAL_W-1:0] val_t;

   // operands as held in the OPERAND register
   typedef struct packed {
      val_t a;
      val_t b;
      val_t c;   // offset added to the product
   } operand_t;

   typedef logic [LANES-1:0] lanes_t;

   typedef logic [RESULT_W-1:0] result_t;

   // sequencer outputs to the datapath
   typedef struct packed {
      logic gen_en;    // stream counters advance
      logic load;      // stream registers shift in
      logic rotate;    // register a wraps
      logic acc_clr;   // lane counters cleared
      logic acc_en;    // lane counters count
   } seq_ctrl_t;

endpackage

`default_nettype wire

//--- src/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

   localparam int ADDR_W = 4;
   localparam int DATA_W = 32;

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [ADDR_W-1:0] paddr;
      logic [DATA_W-1:0] pwdata;
   } apb_req_t;

   // no pready, every transfer is zero wait state
   typedef struct packed {
      logic [DATA_W-1:0] prdata;
      logic              pslverr;
   } apb_rsp_t;

   // register map
   localparam logic [ADDR_W-1:0] OPERAND_OFS = 4'h0;
   localparam logic [ADDR_W-1:0] CTRL_OFS    = 4'h4;
   localparam logic [ADDR_W-1:0] STATUS_OFS  = 4'h8;
   localparam logic [ADDR_W-1:0] RESULT_OFS  = 4'hC;

   // OPERAND fields
   localparam int A_LSB = 0;
   localparam int B_LSB = 8;
   localparam int C_LSB = 16;

   // STATUS fields
   localparam int BUSY_BIT = 0;
   localparam int DONE_BIT = 1;

   // CTRL fields
   localparam int START_BIT = 0;   // write 1 to launch a run

endpackage

`default_nettype wire

//--- src/apb_csr.sv
`timescale 1ns/1ps
`default_nettype none

module apb_csr (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire apb_regs_pkg::apb_req_t apb_req,
   output apb_regs_pkg::apb_rsp_t      apb_rsp,
   input  wire logic                   busy,
   input  wire sc_pkg::result_t        result,
   output sc_pkg::operand_t            operands,
   output logic                        start
);

   sc_pkg::operand_t operand_q;
   logic             done_q;
   logic             busy_q;
   logic             access;
   logic             addr_ok;
   logic             wr_err;
   logic             wr_ok;
   logic             start_bit;

   assign access    = apb_req.psel & apb_req.penable;
   assign start_bit = apb_req.pwdata[apb_regs_pkg::START_BIT];

   // address decode and write protection
   always_comb begin
      addr_ok = 1'b1;
      wr_err  = 1'b0;
      case (apb_req.paddr)
         apb_regs_pkg::OPERAND_OFS: wr_err = busy;
         apb_regs_pkg::CTRL_OFS:    wr_err = busy & start_bit;
         apb_regs_pkg::STATUS_OFS,
         apb_regs_pkg::RESULT_OFS:  wr_err = 1'b1;   // read only
         default:                   addr_ok = 1'b0;
      endcase
   end

   assign wr_ok = access & apb_req.pwrite & addr_ok & ~wr_err;
   assign start = wr_ok & (apb_req.paddr == apb_regs_pkg::CTRL_OFS) & start_bit;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         operand_q <= '0;
      end else if (wr_ok && apb_req.paddr == apb_regs_pkg::OPERAND_OFS) begin
         operand_q.a <= apb_req.pwdata[apb_regs_pkg::A_LSB +: sc_pkg::VAL_W];
         operand_q.b <= apb_req.pwdata[apb_regs_pkg::B_LSB +: sc_pkg::VAL_W];
         operand_q.c <= apb_req.pwdata[apb_regs_pkg::C_LSB +: sc_pkg::VAL_W];
      end
   end

   // done rises one cycle after busy drops
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         busy_q <= busy;
         if (start) begin
            done_q <= 1'b0;
         end else if (busy_q && !busy) begin
            done_q <= 1'b1;
         end
      end
   end

   assign operands = operand_q;

   always_comb begin
      apb_rsp.prdata = '0;
      case (apb_req.paddr)
         apb_regs_pkg::OPERAND_OFS: begin
            apb_rsp.prdata[apb_regs_pkg::A_LSB +: sc_pkg::VAL_W] = operand_q.a;
            apb_rsp.prdata[apb_regs_pkg::B_LSB +: sc_pkg::VAL_W] = operand_q.b;
            apb_rsp.prdata[apb_regs_pkg::C_LSB +: sc_pkg::VAL_W] = operand_q.c;
         end
         apb_regs_pkg::STATUS_OFS: begin
            apb_rsp.prdata[apb_regs_pkg::BUSY_BIT] = busy;
            apb_rsp.prdata[apb_regs_pkg::DONE_BIT] = done_q;
         end
         apb_regs_pkg::RESULT_OFS: begin
            apb_rsp.prdata[sc_pkg::RESULT_W-1:0] = result;
         end
         default: begin
            apb_rsp.prdata = '0;   // CTRL reads as zero
         end
      endcase
      apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & wr_err));
   end

endmodule

`default_nettype wire

//--- src/sc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sc_sequencer (
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         start,
   output sc_pkg::seq_ctrl_t ctrl,
   output logic              busy
);

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      ROTATE
   } state_t;

   state_t                         state;
   logic [sc_pkg::PHASE_CNT_W-1:0] phase;
   logic                           last;

   // final cycle of a phase, counter wraps to 0 after it
   assign last = (phase == sc_pkg::STREAM_LEN - 1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
         phase <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= LOAD;
               end
            end
            LOAD: begin
               if (last) begin
                  state <= ROTATE;
               end
            end
            ROTATE: begin
               if (last) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase

         if (state == IDLE) begin
            phase <= '0;
         end else begin
            phase <= phase + 1'b1;
         end
      end
   end

   always_comb begin
      ctrl.gen_en  = (state == LOAD);
      ctrl.load    = (state == LOAD);
      ctrl.acc_clr = (state == LOAD) && (phase == '0);   // first load cycle
      ctrl.rotate  = (state == ROTATE);
      ctrl.acc_en  = (state == ROTATE);
   end

   assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- src/bin_to_stoch.sv
`timescale 1ns/1ps
`default_nettype none

module bin_to_stoch (
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         gen_en,
   input  wire sc_pkg::val_t value,
   output logic              stream_bit
);

   sc_pkg::val_t             count;
   logic [sc_pkg::VAL_W-1:0] gt;         // value bit set, count bit clear
   logic [sc_pkg::VAL_W-1:0] hit;
   logic [sc_pkg::VAL_W-1:1] eq;
   logic [sc_pkg::VAL_W:1]   eq_above;   // all higher bits equal

   // wraps back to 0 after a full load
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (gen_en) begin
         count <= count + 1'b1;
      end
   end

   assign eq_above[sc_pkg::VAL_W] = 1'b1;

   // value > count, msb first
   for (genvar i = 0; i < sc_pkg::VAL_W; i++) begin : g_bit
      assign gt[i]  = value[i] & ~count[i];
      assign hit[i] = gt[i] & eq_above[i+1];
      if (i > 0) begin : g_eq
         assign eq[i]       = ~(value[i] ^ count[i]);
         assign eq_above[i] = eq_above[i+1] & eq[i];
      end
   end

   assign stream_bit = |hit;

endmodule

`default_nettype wire

//--- src/stream_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stream_shift_reg (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       load,
   input  wire logic       rotate,
   input  wire logic       serial_in,
   output sc_pkg::lanes_t  taps
);

   logic [sc_pkg::STREAM_LEN-1:0] sr;
   logic                          shift_in;

   // top bit wraps around when rotating
   assign shift_in = load ? serial_in : sr[sc_pkg::STREAM_LEN-1];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sr <= '0;
      end else if (load || rotate) begin
         sr <= {sr[sc_pkg::STREAM_LEN-2:0], shift_in};
      end
   end

   // oldest stream bits sit at the top
   assign taps = sr[sc_pkg::STREAM_LEN-1 -: sc_pkg::LANES];

endmodule

`default_nettype wire

//--- src/stoch_to_bin.sv
`timescale 1ns/1ps
`default_nettype none

module stoch_to_bin (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            acc_clr,
   input  wire logic            acc_en,
   input  wire sc_pkg::lanes_t  taps_a,
   input  wire sc_pkg::lanes_t  taps_b,
   input  wire sc_pkg::val_t    offset,
   output sc_pkg::result_t      result
);

   sc_pkg::lanes_t                 hit;
   logic [sc_pkg::LANE_CNT_W-1:0] cnt [sc_pkg::LANES];
   sc_pkg::result_t                node [1:2*sc_pkg::LANES-1];

   assign hit = taps_a & taps_b;   // the multiply, one AND per lane

   // ones-counter per lane
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < sc_pkg::LANES; i++) begin
            cnt[i] <= '0;
         end
      end else if (acc_clr) begin
         for (int i = 0; i < sc_pkg::LANES; i++) begin
            cnt[i] <= '0;
         end
      end else if (acc_en) begin
         for (int i = 0; i < sc_pkg::LANES; i++) begin
            if (hit[i]) begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   // binary adder tree, leaves at LANES..2*LANES-1, root at 1
   always_comb begin
      for (int i = 0; i < sc_pkg::LANES; i++) begin
         node[sc_pkg::LANES+i] = sc_pkg::result_t'(cnt[i]);
      end
      for (int i = sc_pkg::LANES - 1; i >= 1; i--) begin
         node[i] = node[2*i] + node[2*i+1];
      end
   end

   assign result = node[1] + sc_pkg::result_t'(offset);

endmodule

`default_nettype wire

//--- src/sc_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

module sc_mul_top (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire apb_regs_pkg::apb_req_t apb_req,
   output apb_regs_pkg::apb_rsp_t      apb_rsp
);

   sc_pkg::operand_t  operands;
   sc_pkg::seq_ctrl_t ctrl;
   sc_pkg::result_t   result;
   sc_pkg::lanes_t    taps_a;
   sc_pkg::lanes_t    taps_b;
   logic              start;
   logic              busy;
   logic              stream_a;
   logic              stream_b;

   apb_csr u_apb_csr (
      .clk      (clk),
      .rst      (rst),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .busy     (busy),
      .result   (result),
      .operands (operands),
      .start    (start)
   );

   sc_sequencer u_sequencer (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .ctrl  (ctrl),
      .busy  (busy)
   );

   bin_to_stoch u_gen_a (
      .clk        (clk),
      .rst        (rst),
      .gen_en     (ctrl.gen_en),
      .value      (operands.a),
      .stream_bit (stream_a)
   );

   bin_to_stoch u_gen_b (
      .clk        (clk),
      .rst        (rst),
      .gen_en     (ctrl.gen_en),
      .value      (operands.b),
      .stream_bit (stream_b)
   );

   stream_shift_reg u_sr_a (
      .clk       (clk),
      .rst       (rst),
      .load      (ctrl.load),
      .rotate    (ctrl.rotate),
      .serial_in (stream_a),
      .taps      (taps_a)
   );

   // b holds still after the load
   stream_shift_reg u_sr_b (
      .clk       (clk),
      .rst       (rst),
      .load      (ctrl.load),
      .rotate    (1'b0),
      .serial_in (stream_b),
      .taps      (taps_b)
   );

   stoch_to_bin u_stoch_to_bin (
      .clk     (clk),
      .rst     (rst),
      .acc_clr (ctrl.acc_clr),
      .acc_en  (ctrl.acc_en),
      .taps_a  (taps_a),
      .taps_b  (taps_b),
      .offset  (operands.c),
      .result  (result)
   );

endmodule

`default_nettype wire

//--- sim/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// one zero-wait APB transfer, entered just after a rising edge
task automatic apb_transfer(input logic write, input logic [apb_regs_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
   apb_req.psel    = 1'b1;   // setup
   apb_req.penable = 1'b0;
   apb_req.pwrite  = write;
   apb_req.paddr   = addr;
   apb_req.pwdata  = wdata;
   @(posedge clk);
   #DRIVE_DLY;
   apb_req.penable = 1'b1;   // access
   @(negedge clk);
   rdata = apb_rsp.prdata;
   err   = apb_rsp.pslverr;
   @(posedge clk);
   #DRIVE_DLY;
   apb_req.psel    = 1'b0;
   apb_req.penable = 1'b0;
endtask

task automatic apb_write(input logic [apb_regs_pkg::ADDR_W-1:0] addr,
                         input logic [31:0] wdata, output logic err);
   logic [31:0] unused;
   apb_transfer(1'b1, addr, wdata, unused, err);
endtask

task automatic apb_read(input logic [apb_regs_pkg::ADDR_W-1:0] addr,
                        output logic [31:0] rdata, output logic err);
   apb_transfer(1'b0, addr, '0, rdata, err);
endtask

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_bits(input int n, output logic [31:0] v);
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
   end
endtask

// only the first LANES bits of stream b reach the AND lanes
function automatic int expected_product(input int a, input int b, input int c);
   int b_used;
   b_used = (b > sc_pkg::LANES) ? sc_pkg::LANES : b;
   return a * b_used + c;
endfunction

`endif

//--- sim/tb_sc_mul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sc_mul;

   localparam time DRIVE_DLY       = 1ns;
   localparam int  WATCHDOG_CYCLES = 40 * 80 + 500;
   localparam int  MAX_POLLS       = 60;

   logic                   clk;
   logic                   rst;
   apb_regs_pkg::apb_req_t apb_req;
   apb_regs_pkg::apb_rsp_t apb_rsp;
   logic [31:0]            lfsr_q;

   sc_mul_top u_sc_mul_top (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   `include "tb_apb_tasks.svh"

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      assert (actual == expected)
      else fail_now($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
   endtask

   function automatic logic [31:0] pack_operands(input int a, input int b, input int c);
      logic [31:0] w;
      w = '0;
      w[apb_regs_pkg::A_LSB +: sc_pkg::VAL_W] = a;
      w[apb_regs_pkg::B_LSB +: sc_pkg::VAL_W] = b;
      w[apb_regs_pkg::C_LSB +: sc_pkg::VAL_W] = c;
      return w;
   endfunction

   task automatic start_run(input string name, input int a, input int b, input int c);
      logic err;
      apb_write(apb_regs_pkg::OPERAND_OFS, pack_operands(a, b, c), err);
      check_value({name, " operand pslverr"}, 0, err);
      apb_write(apb_regs_pkg::CTRL_OFS, 32'h1 << apb_regs_pkg::START_BIT, err);
      check_value({name, " start pslverr"}, 0, err);
   endtask

   // poll STATUS until done, then check the result
   task automatic finish_run(input string name, input int expected);
      logic [31:0] rdata;
      logic        err;
      int          polls;
      polls = 0;
      rdata = '0;
      while (!rdata[apb_regs_pkg::DONE_BIT]) begin
         if (polls == MAX_POLLS) begin
            fail_now($sformatf("%s never reported done", name));
         end
         apb_read(apb_regs_pkg::STATUS_OFS, rdata, err);
         check_value({name, " status pslverr"}, 0, err);
         polls++;
      end
      check_value({name, " busy after done"}, 0, rdata[apb_regs_pkg::BUSY_BIT]);
      apb_read(apb_regs_pkg::RESULT_OFS, rdata, err);
      check_value({name, " result pslverr"}, 0, err);
      check_value(name, expected, rdata);
   endtask

   task automatic multiply(input string name, input int a, input int b, input int c);
      start_run(name, a, b, c);
      finish_run(name, expected_product(a, b, c));
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_now("watchdog expired, the run timed out");
   end

   initial begin
      logic [31:0] rdata;
      logic [31:0] wdata;
      logic [31:0] ra;
      logic [31:0] rb;
      logic [31:0] rc;
      logic        err;
      rst     = 1'b1;
      apb_req = '0;
      lfsr_q  = 32'hed05;
      repeat (2) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;

      // reset state
      apb_read(apb_regs_pkg::OPERAND_OFS, rdata, err);
      check_value("reset operand", 0, rdata);
      check_value("reset operand pslverr", 0, err);
      apb_read(apb_regs_pkg::STATUS_OFS, rdata, err);
      check_value("reset status", 0, rdata);
      check_value("reset status pslverr", 0, err);
      apb_read(apb_regs_pkg::RESULT_OFS, rdata, err);
      check_value("reset result", 0, rdata);
      check_value("reset result pslverr", 0, err);

      // register access
      random_bits(15, wdata);
      wdata = pack_operands(wdata[4:0], wdata[9:5], wdata[14:10]);
      apb_write(apb_regs_pkg::OPERAND_OFS, wdata, err);
      check_value("operand write pslverr", 0, err);
      apb_write(4'h2, 32'hffff_ffff, err);
      check_value("unmapped write pslverr", 1, err);
      apb_write(apb_regs_pkg::STATUS_OFS, 32'h3, err);
      check_value("status write pslverr", 1, err);
      apb_write(apb_regs_pkg::RESULT_OFS, 32'h3ff, err);
      check_value("result write pslverr", 1, err);
      apb_read(apb_regs_pkg::OPERAND_OFS, rdata, err);
      check_value("operand readback", wdata, rdata);

      // corners
      multiply("corner full scale", 31, 31, 31);
      multiply("corner a zero", 0, 22, 9);
      multiply("corner b zero", 17, 0, 12);
      multiply("corner b 16", 11, 16, 3);
      multiply("corner b 20", 11, 20, 3);

      // run timing with access cycles 63 and 65 after the start edge
      start_run("timing", 7, 5, 2);
      repeat (62) @(posedge clk);
      #DRIVE_DLY;
      apb_read(apb_regs_pkg::STATUS_OFS, rdata, err);
      check_value("timing status at 63", 1 << apb_regs_pkg::BUSY_BIT, rdata);
      apb_read(apb_regs_pkg::STATUS_OFS, rdata, err);
      check_value("timing status at 65", 1 << apb_regs_pkg::DONE_BIT, rdata);
      apb_read(apb_regs_pkg::RESULT_OFS, rdata, err);
      check_value("timing result", expected_product(7, 5, 2), rdata);

      for (int i = 0; i < 30; i++) begin
         random_bits(sc_pkg::VAL_W, ra);
         random_bits(sc_pkg::VAL_W, rb);
         random_bits(sc_pkg::VAL_W, rc);
         multiply($sformatf("random run %0d", i), ra, rb, rc);
      end

      // writes during a run are refused
      start_run("busy protection", 13, 9, 6);
      apb_write(apb_regs_pkg::OPERAND_OFS, pack_operands(31, 31, 31), err);
      check_value("busy operand write pslverr", 1, err);
      apb_write(apb_regs_pkg::CTRL_OFS, 32'h1 << apb_regs_pkg::START_BIT, err);
      check_value("busy start write pslverr", 1, err);
      finish_run("busy protection", expected_product(13, 9, 6));

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+sim
src/sc_pkg.sv
src/apb_regs_pkg.sv
src/apb_csr.sv
src/sc_sequencer.sv
src/bin_to_stoch.sv
src/stream_shift_reg.sv
src/stoch_to_bin.sv
src/sc_mul_top.sv
sim/tb_sc_mul.sv
